// ==== sources.f ====
common/vgaPkg.sv
logic/scanTimer.sv
logic/scanPhaseFsm.sv
pixel/pixelAddressGen.sv
pixel/pixelOutput.sv
logic/vgaController.sv
verif/vgaController_props.sv
verif/vgaControllerTb.sv

// ==== verif/vgaControllerTb.sv ====
`timescale 1ns/100ps

module vgaControllerTb;

	localparam int H_VISIBLE_END = 15;
	localparam int H_FRONT_END = 17;
	localparam int H_SYNC_END = 19;
	localparam int H_WHOLE_END = 23;
	localparam int V_VISIBLE_END = 3;
	localparam int V_FRONT_END = 4;
	localparam int V_SYNC_END = 5;
	localparam int V_WHOLE_END = 7;
	localparam int LINE_CYCLES = H_WHOLE_END + 1;
	localparam int FRAME_CYCLES = LINE_CYCLES * (V_WHOLE_END + 1);
	localparam int CLOCK_PERIOD = 40;

	typedef struct packed {
		logic [3:0] hSize;
		logic [3:0] vSize;
		vgaPkg::drawMode_e mode;
		logic hIrqEnable;
		logic vIrqEnable;
		int frames;
		int wordsPerLine;
	} testRow_t;

	// Pixel sizes, mode, irq enables, frames to run, words fetched per visible line
	localparam testRow_t TESTS [5] = '{
		'{4'd1, 4'd1, vgaPkg::DRAW_RAW, 1'b1, 1'b1, 2, 4},
		'{4'd1, 4'd1, vgaPkg::DRAW_TIGHT, 1'b0, 1'b1, 2, 4},
		'{4'd2, 4'd2, vgaPkg::DRAW_RAW, 1'b1, 1'b0, 2, 2},
		'{4'd3, 4'd2, vgaPkg::DRAW_TIGHT, 1'b1, 1'b1, 2, 2},
		'{4'd4, 4'd3, vgaPkg::DRAW_TIGHT, 1'b0, 1'b0, 1, 1}
	};

	logic vga_clk = 1'b0;
	logic rst;
	vgaPkg::vgaConfig_t vgaConfig;
	logic fetchData;
	logic [vgaPkg::ADDRESS_BITS-1:0] address;
	logic [31:0] pixelData;
	vgaPkg::colour_t colour;
	logic hsync;
	logic vsync;
	logic [1:0] irq;

	testRow_t curRow;
	logic monitorOn = 1'b0;
	int errorCount = 0;
	int checkCount = 0;
	int framesSeen = 0;
	int linesChecked = 0;
	int lineIdx = 0;
	int cycle = 0;
	int lastHFall = 0;
	int lastVFall = 0;
	int fetchCount = 0;
	logic prevHsync = 1'b1;
	logic prevVsync = 1'b1;
	logic [12:0] lineFetches [$];
	logic [5:0] lineColours [$];
	logic [31:0] wordMap [logic [12:0]];
	logic [18:0] randomPool [256];

	always #(CLOCK_PERIOD / 2) vga_clk = !vga_clk;

	vgaController #(
		.H_VISIBLE_END(H_VISIBLE_END),
		.H_FRONT_END(H_FRONT_END),
		.H_SYNC_END(H_SYNC_END),
		.H_WHOLE_END(H_WHOLE_END),
		.V_VISIBLE_END(V_VISIBLE_END),
		.V_FRONT_END(V_FRONT_END),
		.V_SYNC_END(V_SYNC_END),
		.V_WHOLE_END(V_WHOLE_END)
	) vgaController_inst (
		.vga_clk(vga_clk),
		.rst(rst),
		.vgaConfig(vgaConfig),
		.fetchData(fetchData),
		.address(address),
		.pixelData(pixelData),
		.colour(colour),
		.hsync(hsync),
		.vsync(vsync),
		.irq(irq)
	);

	function automatic logic [12:0] expectedAddress(input int line, input int word);
		int row;
		int index;
		row = line / curRow.vSize;
		index = row * curRow.wordsPerLine + word;
		if (curRow.mode == vgaPkg::DRAW_RAW)
			return {7'(row), 4'(word), 2'b00};
		return {11'(index), 2'b00};
	endfunction

	// Red from bits 1:0, green from 3:2, blue from 5:4
	function automatic logic [5:0] pixelColour(input logic [31:0] word, input int sub);
		logic [5:0] p;
		p = word[sub * 6 +: 6];
		return {p[1:0], p[3:2], p[5:4]};
	endfunction

	task automatic reportMismatch(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		errorCount++;
		$display("** Error %s: expected %h, got %h", what, expected, actual);
	endtask

	task automatic checkLine();
		int expectedFetches;
		int column;
		logic [12:0] addr;
		logic [5:0] expectedColours [$];
		expectedFetches = lineIdx <= V_VISIBLE_END ? curRow.wordsPerLine : 0;
		linesChecked++;
		checkCount++;
		if (lineFetches.size() != expectedFetches) begin
			reportMismatch($sformatf("fetch count (line %0d)", lineIdx), expectedFetches,
				lineFetches.size());
			return;
		end
		for (int w = 0; w < expectedFetches; w++) begin
			checkCount++;
			if (lineFetches[w] !== expectedAddress(lineIdx, w))
				reportMismatch($sformatf("address (line %0d word %0d)", lineIdx, w),
					expectedAddress(lineIdx, w), lineFetches[w]);
		end
		// Zero pixels cannot be told apart from blanking
		for (int x = 0; expectedFetches > 0 && x <= H_VISIBLE_END; x++) begin
			column = x / (5 * curRow.hSize);
			addr = expectedAddress(lineIdx, column);
			if (!wordMap.exists(addr)) begin
				errorCount++;
				$display("No word was fetched for address %h on line %0d", addr, lineIdx);
				return;
			end
			if (pixelColour(wordMap[addr], (x / curRow.hSize) % 5) != 0)
				expectedColours.push_back(pixelColour(wordMap[addr], (x / curRow.hSize) % 5));
		end
		checkCount++;
		if (lineColours.size() != expectedColours.size()) begin
			reportMismatch($sformatf("colour count (line %0d)", lineIdx),
				expectedColours.size(), lineColours.size());
			return;
		end
		foreach (expectedColours[i]) begin
			if (lineColours[i] !== expectedColours[i])
				reportMismatch($sformatf("colour (line %0d pixel %0d)", lineIdx, i),
					expectedColours[i], lineColours[i]);
		end
	endtask

	// Memory answers every fetch on the next cycle
	always @(posedge vga_clk) begin
		if (fetchData === 1'b1) begin
			wordMap[address] = {randomPool[fetchCount % 256], address};
			pixelData <= {randomPool[fetchCount % 256], address};
			lineFetches.push_back(address);
			fetchCount++;
		end
	end

	always @(posedge vga_clk) begin
		logic [1:0] irqExpected;
		if (!monitorOn) begin
			checkCount++;
			if ({hsync, vsync, colour, fetchData, irq} !== 11'h600)
				reportMismatch("idle {hsync, vsync, colour, fetchData, irq}", 11'h600,
					{hsync, vsync, colour, fetchData, irq});
			lineFetches.delete();
			lineColours.delete();
			lineIdx = 0;
			cycle = 0;
			lastHFall = -1;
			lastVFall = -1;
			prevHsync = 1'b1;
			prevVsync = 1'b1;
		end else begin
			cycle++;
			irqExpected = {curRow.vIrqEnable && prevVsync && !vsync,
				curRow.hIrqEnable && prevHsync && !hsync};
			checkCount++;
			if (irq !== irqExpected)
				reportMismatch("irq", irqExpected, irq);
			if (colour != 0)
				lineColours.push_back(colour);
			if (prevVsync && !vsync) begin
				checkCount++;
				if (lineIdx != V_FRONT_END + 1)
					reportMismatch("vsync start line", V_FRONT_END + 1, lineIdx);
				if (lastVFall >= 0 && cycle - lastVFall != FRAME_CYCLES)
					reportMismatch("vsync period", FRAME_CYCLES, cycle - lastVFall);
				lastVFall = cycle;
				framesSeen <= framesSeen + 1;
			end
			if (!prevVsync && vsync && cycle - lastVFall != (V_SYNC_END - V_FRONT_END) * LINE_CYCLES)
				reportMismatch("vsync low width", (V_SYNC_END - V_FRONT_END) * LINE_CYCLES,
					cycle - lastVFall);
			if (!prevHsync && hsync && cycle - lastHFall != H_SYNC_END - H_FRONT_END)
				reportMismatch("hsync low width", H_SYNC_END - H_FRONT_END, cycle - lastHFall);
			if (prevHsync && !hsync) begin
				checkCount++;
				if (lastHFall >= 0 && cycle - lastHFall != LINE_CYCLES)
					reportMismatch("hsync period", LINE_CYCLES, cycle - lastHFall);
				lastHFall = cycle;
				checkLine();
				lineIdx = (lineIdx + 1) % (V_WHOLE_END + 1);
				lineFetches.delete();
				lineColours.delete();
			end
			prevHsync = hsync;
			prevVsync = vsync;
		end
	end

	initial begin
		vgaPkg::vgaConfig_t cfg;
		int rowErrors;
		int rowLines;
		int totalErrors;
		void'($urandom(32'h17c5));
		foreach (randomPool[i])
			randomPool[i] = 19'($urandom);
		rst = 1'b1;
		vgaConfig = '0;
		pixelData = '0;
		curRow = TESTS[0];
		// Output enabled while reset holds so reset alone has to keep the outputs idle
		@(posedge vga_clk);
		vgaConfig.enableOutput <= 1'b1;
		repeat (2) @(posedge vga_clk);
		rst <= 1'b0;
		vgaConfig <= '0;
		for (int i = 0; i < $size(TESTS); i++) begin
			curRow = TESTS[i];
			rowErrors = errorCount;
			rowLines = linesChecked;
			framesSeen = 0;
			cfg = '0;
			cfg.horizontalPixelSize = curRow.hSize;
			cfg.verticalPixelSize = curRow.vSize;
			cfg.drawMode = curRow.mode;
			cfg.hsyncIrqEnable = curRow.hIrqEnable;
			cfg.vsyncIrqEnable = curRow.vIrqEnable;
			cfg.enableOutput = 1'b1;
			@(posedge vga_clk);
			vgaConfig <= cfg;
			monitorOn <= 1'b1;
			do
				@(posedge vga_clk);
			while (framesSeen < curRow.frames);
			vgaConfig.enableOutput <= 1'b0;
			monitorOn <= 1'b0;
			repeat (4) @(posedge vga_clk);
			$display("Test %0d: %s mode, pixel size %0dx%0d, %0d frames, %0d lines, %0d errors",
				i, curRow.mode == vgaPkg::DRAW_RAW ? "raw" : "tight", curRow.hSize,
				curRow.vSize, curRow.frames, linesChecked - rowLines, errorCount - rowErrors);
		end
		totalErrors = errorCount + vgaController_inst.vgaController_props_inst.failCount;
		$display("Summary: %0d checks, %0d lines, %0d errors, %0d assertion failures",
			checkCount, linesChecked, errorCount,
			vgaController_inst.vgaController_props_inst.failCount);
		if (totalErrors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// Each row may spend most of a frame before its first vsync
	initial begin
		int totalFrames;
		longint limit;
		totalFrames = 0;
		for (int i = 0; i < $size(TESTS); i++)
			totalFrames += TESTS[i].frames;
		limit = (longint'(totalFrames + $size(TESTS)) * FRAME_CYCLES * 2 + 100) * CLOCK_PERIOD;
		#(limit);
		$display("Timeout: the run did not finish within %0d ns", limit);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== verif/vgaController_props.sv ====
`timescale 1ns/100ps

module vgaController_props (
	input logic vga_clk,
	input logic rst,
	input vgaPkg::vgaConfig_t vgaConfig,
	input logic fetchData,
	input vgaPkg::colour_t colour,
	input logic hsync,
	input logic vsync,
	input logic [1:0] irq
);

	int failCount = 0;

	// Interrupt strobes last a single cycle
	hsyncIrqPulse: assert property (@(posedge vga_clk) disable iff (rst) irq[0] |=> !irq[0])
		else begin
			failCount++;
			$error("hsync interrupt high for two cycles in a row");
		end

	vsyncIrqPulse: assert property (@(posedge vga_clk) disable iff (rst) irq[1] |=> !irq[1])
		else begin
			failCount++;
			$error("vsync interrupt high for two cycles in a row");
		end

	// Sync pulses fall outside the visible area
	blankDuringSync: assert property (@(posedge vga_clk) disable iff (rst)
			(!hsync || !vsync) |-> colour == '0)
		else begin
			failCount++;
			$error("colour not blanked while sync is low");
		end

	// Scan state is cleared by the disabled cycle, so no fetch follows it either
	noFetchWhenOff: assert property (@(posedge vga_clk)
			!vgaConfig.enableOutput |-> !fetchData ##1 !fetchData)
		else begin
			failCount++;
			$error("fetch strobe while output is disabled or right after");
		end

endmodule

bind vgaController vgaController_props vgaController_props_inst (.*);

// ==== logic/vgaController.sv ====
`timescale 1ns/100ps

module vgaController #(
	// Defaults give 800 x 600 at 60 Hz
	parameter logic [vgaPkg::H_COUNT_BITS-1:0] H_VISIBLE_END = 799,
	parameter logic [vgaPkg::H_COUNT_BITS-1:0] H_FRONT_END = 839,
	parameter logic [vgaPkg::H_COUNT_BITS-1:0] H_SYNC_END = 967,
	parameter logic [vgaPkg::H_COUNT_BITS-1:0] H_WHOLE_END = 1055,
	parameter logic [vgaPkg::V_COUNT_BITS-1:0] V_VISIBLE_END = 599,
	parameter logic [vgaPkg::V_COUNT_BITS-1:0] V_FRONT_END = 600,
	parameter logic [vgaPkg::V_COUNT_BITS-1:0] V_SYNC_END = 604,
	parameter logic [vgaPkg::V_COUNT_BITS-1:0] V_WHOLE_END = 627
)(
	input logic vga_clk,
	input logic rst,
	input vgaPkg::vgaConfig_t vgaConfig,

	// Frame-buffer port
	output logic fetchData,
	output logic [vgaPkg::ADDRESS_BITS-1:0] address,
	input logic [31:0] pixelData,

	output vgaPkg::colour_t colour,
	output logic hsync,
	output logic vsync,
	output logic [1:0] irq
);

	vgaPkg::scanEvents_t events;
	logic hVisible;
	logic vVisible;
	logic [2:0] subPixelIndex;

	scanTimer #(
		.H_VISIBLE_END(H_VISIBLE_END),
		.H_FRONT_END(H_FRONT_END),
		.H_SYNC_END(H_SYNC_END),
		.H_WHOLE_END(H_WHOLE_END),
		.V_VISIBLE_END(V_VISIBLE_END),
		.V_FRONT_END(V_FRONT_END),
		.V_SYNC_END(V_SYNC_END),
		.V_WHOLE_END(V_WHOLE_END)
	) scanTimer_inst (
		.vga_clk(vga_clk),
		.rst(rst),
		.vgaConfig(vgaConfig),
		.events(events)
	);

	scanPhaseFsm #(
		.H_VISIBLE_END(H_VISIBLE_END),
		.H_FRONT_END(H_FRONT_END),
		.H_SYNC_END(H_SYNC_END),
		.H_WHOLE_END(H_WHOLE_END),
		.V_VISIBLE_END(V_VISIBLE_END),
		.V_FRONT_END(V_FRONT_END),
		.V_SYNC_END(V_SYNC_END),
		.V_WHOLE_END(V_WHOLE_END)
	) scanPhaseFsm_inst (
		.vga_clk(vga_clk),
		.rst(rst),
		.vgaConfig(vgaConfig),
		.events(events),
		.hVisible(hVisible),
		.vVisible(vVisible),
		.hsync(hsync),
		.vsync(vsync),
		.irq(irq)
	);

	pixelAddressGen pixelAddressGen_inst (
		.vga_clk(vga_clk),
		.rst(rst),
		.vgaConfig(vgaConfig),
		.events(events),
		.hVisible(hVisible),
		.vVisible(vVisible),
		.address(address),
		.fetchData(fetchData),
		.subPixelIndex(subPixelIndex)
	);

	pixelOutput pixelOutput_inst (
		.vga_clk(vga_clk),
		.rst(rst),
		.vgaConfig(vgaConfig),
		.hVisible(hVisible),
		.vVisible(vVisible),
		.fetchData(fetchData),
		.subPixelIndex(subPixelIndex),
		.pixelData(pixelData),
		.colour(colour)
	);

endmodule

// ==== pixel/pixelOutput.sv ====
`timescale 1ns/100ps

module pixelOutput (
	input logic vga_clk,
	input logic rst,
	input vgaPkg::vgaConfig_t vgaConfig,
	input logic hVisible,
	input logic vVisible,
	input logic fetchData,
	input logic [2:0] subPixelIndex,
	input logic [31:0] pixelData,
	output vgaPkg::colour_t colour
);

	logic fetchDelayed;
	logic onScreenStage1;
	logic onScreenStage2;
	logic [2:0] subPixelStage1;
	logic [2:0] subPixelStage2;
	logic [31:0] word;
	logic [vgaPkg::PIXEL_BITS-1:0] pixel;

	// Fetch, data valid, latch, so the flags trail the scan by two cycles
	always_ff @(posedge vga_clk) begin
		if (rst || !vgaConfig.enableOutput) begin
			fetchDelayed <= 1'b0;
			onScreenStage1 <= 1'b0;
			onScreenStage2 <= 1'b0;
		end else begin
			fetchDelayed <= fetchData;
			onScreenStage1 <= hVisible && vVisible;
			onScreenStage2 <= onScreenStage1;
		end
	end

	always_ff @(posedge vga_clk) begin
		subPixelStage1 <= subPixelIndex;
		subPixelStage2 <= subPixelStage1;
		if (fetchDelayed)
			word <= pixelData;
	end

	always_comb begin
		if (subPixelStage2 < 3'(vgaPkg::SUB_PIXELS))
			pixel = word[subPixelStage2 * vgaPkg::PIXEL_BITS +: vgaPkg::PIXEL_BITS];
		else
			pixel = '0;

		if (vgaConfig.enableOutput && onScreenStage2) begin
			colour.red = pixel[1:0];
			colour.green = pixel[3:2];
			colour.blue = pixel[5:4];
		end else begin
			colour = '0;
		end
	end

endmodule

// ==== pixel/pixelAddressGen.sv ====
`timescale 1ns/100ps

module pixelAddressGen (
	input logic vga_clk,
	input logic rst,
	input vgaPkg::vgaConfig_t vgaConfig,
	input vgaPkg::scanEvents_t events,
	input logic hVisible,
	input logic vVisible,
	output logic [vgaPkg::ADDRESS_BITS-1:0] address,
	output logic fetchData,
	output logic [2:0] subPixelIndex
);

	// Word index width once the byte offset is dropped
	localparam int INDEX_BITS = vgaPkg::ADDRESS_BITS - 2;

	logic [vgaPkg::PIXEL_SIZE_BITS-1:0] hStretch;
	logic [vgaPkg::PIXEL_SIZE_BITS-1:0] vStretch;
	logic [2:0] subPixel;
	logic [INDEX_BITS-1:0] column;
	logic [vgaPkg::ROW_FIELD_BITS-1:0] row;
	logic [INDEX_BITS-1:0] rowBase;
	logic [INDEX_BITS-1:0] linearIndex;
	logic [vgaPkg::ADDRESS_BITS-1:0] rawAddress;
	logic [vgaPkg::ADDRESS_BITS-1:0] tightAddress;
	logic onScreen;
	logic hStep;
	logic vStep;
	logic lastSubPixel;

	assign onScreen = hVisible && vVisible;
	assign hStep = hStretch == vgaConfig.horizontalPixelSize - 1'b1;
	assign vStep = vStretch == vgaConfig.verticalPixelSize - 1'b1;
	assign lastSubPixel = subPixel == 3'(vgaPkg::SUB_PIXELS - 1);

	// Counters always describe the pixel under the scan position
	always_ff @(posedge vga_clk) begin
		if (rst || !vgaConfig.enableOutput || !onScreen) begin
			hStretch <= '0;
			subPixel <= '0;
			column <= '0;
		end else if (hStep) begin
			hStretch <= '0;
			if (lastSubPixel) begin
				subPixel <= '0;
				column <= column + 1'b1;
			end else begin
				subPixel <= subPixel + 1'b1;
			end
		end else begin
			hStretch <= hStretch + 1'b1;
		end
	end

	// Rows step at the last visible pixel while the column still holds the line width
	always_ff @(posedge vga_clk) begin
		if (rst || !vgaConfig.enableOutput || !vVisible) begin
			vStretch <= '0;
			row <= '0;
			rowBase <= '0;
		end else if (events.hVisibleEnd) begin
			if (vStep) begin
				vStretch <= '0;
				row <= row + 1'b1;
				rowBase <= rowBase + column + 1'b1;
			end else begin
				vStretch <= vStretch + 1'b1;
			end
		end
	end

	assign linearIndex = rowBase + column;
	assign rawAddress = {row, column[vgaPkg::COLUMN_FIELD_BITS-1:0], 2'b00};
	assign tightAddress = {linearIndex, 2'b00};

	always_comb begin
		case (vgaConfig.drawMode)
			vgaPkg::DRAW_RAW: address = rawAddress;
			vgaPkg::DRAW_TIGHT: address = tightAddress;
			default: address = rawAddress;
		endcase
	end

	// New word whenever the first sub-pixel of a column begins
	assign fetchData = vgaConfig.enableOutput && onScreen && hStretch == '0 && subPixel == '0;
	assign subPixelIndex = subPixel;

endmodule

// ==== logic/scanPhaseFsm.sv ====
`timescale 1ns/100ps

module scanPhaseFsm #(
	parameter logic [vgaPkg::H_COUNT_BITS-1:0] H_VISIBLE_END = 799,
	parameter logic [vgaPkg::H_COUNT_BITS-1:0] H_FRONT_END = 839,
	parameter logic [vgaPkg::H_COUNT_BITS-1:0] H_SYNC_END = 967,
	parameter logic [vgaPkg::H_COUNT_BITS-1:0] H_WHOLE_END = 1055,
	parameter logic [vgaPkg::V_COUNT_BITS-1:0] V_VISIBLE_END = 599,
	parameter logic [vgaPkg::V_COUNT_BITS-1:0] V_FRONT_END = 600,
	parameter logic [vgaPkg::V_COUNT_BITS-1:0] V_SYNC_END = 604,
	parameter logic [vgaPkg::V_COUNT_BITS-1:0] V_WHOLE_END = 627
)(
	input logic vga_clk,
	input logic rst,
	input vgaPkg::vgaConfig_t vgaConfig,
	input vgaPkg::scanEvents_t events,
	output logic hVisible,
	output logic vVisible,
	output logic hsync,
	output logic vsync,
	output logic [1:0] irq
);

	vgaPkg::scanPhase_e hPhase;
	vgaPkg::scanPhase_e vPhase;
	vgaPkg::scanPhase_e hNext;
	vgaPkg::scanPhase_e vNext;
	logic hSyncStart;
	logic vSyncStart;

	// Each phase only ever steps forward, so the boundaries have to ascend
	if (!(H_VISIBLE_END < H_FRONT_END && H_FRONT_END < H_SYNC_END
			&& H_SYNC_END < H_WHOLE_END)) begin : gHorizontalOrder
		$error("Horizontal timing boundaries are not ascending");
	end
	if (!(V_VISIBLE_END < V_FRONT_END && V_FRONT_END < V_SYNC_END
			&& V_SYNC_END < V_WHOLE_END)) begin : gVerticalOrder
		$error("Vertical timing boundaries are not ascending");
	end

	// Same phase sequence for both axes
	function automatic vgaPkg::scanPhase_e nextPhase(
		input vgaPkg::scanPhase_e phase,
		input logic visibleEnd,
		input logic frontEnd,
		input logic syncEnd,
		input logic wholeEnd
	);
		nextPhase = phase;
		case (phase)
			vgaPkg::VISIBLE: if (visibleEnd) nextPhase = vgaPkg::FRONT_PORCH;
			vgaPkg::FRONT_PORCH: if (frontEnd) nextPhase = vgaPkg::SYNC;
			vgaPkg::SYNC: if (syncEnd) nextPhase = vgaPkg::BACK_PORCH;
			vgaPkg::BACK_PORCH: if (wholeEnd) nextPhase = vgaPkg::VISIBLE;
			default: nextPhase = vgaPkg::BACK_PORCH;
		endcase
	endfunction

	always_comb begin
		hNext = nextPhase(hPhase, events.hVisibleEnd, events.hFrontEnd,
			events.hSyncEnd, events.hWholeEnd);
		vNext = nextPhase(vPhase, events.vVisibleEnd, events.vFrontEnd,
			events.vSyncEnd, events.vWholeEnd);
	end

	always_ff @(posedge vga_clk) begin
		if (rst || !vgaConfig.enableOutput) begin
			hPhase <= vgaPkg::BACK_PORCH;
			vPhase <= vgaPkg::BACK_PORCH;
			hSyncStart <= 1'b0;
			vSyncStart <= 1'b0;
		end else begin
			hPhase <= hNext;
			// Vertical machine moves once per line
			if (events.lineEnd)
				vPhase <= vNext;
			hSyncStart <= hPhase != vgaPkg::SYNC && hNext == vgaPkg::SYNC;
			vSyncStart <= events.lineEnd && vPhase != vgaPkg::SYNC && vNext == vgaPkg::SYNC;
		end
	end

	assign hVisible = hPhase == vgaPkg::VISIBLE;
	assign vVisible = vPhase == vgaPkg::VISIBLE;

	// Sync is active low
	assign hsync = !(vgaConfig.enableOutput && hPhase == vgaPkg::SYNC);
	assign vsync = !(vgaConfig.enableOutput && vPhase == vgaPkg::SYNC);

	// Strobe lands in the first cycle of the sync pulse
	assign irq = {vSyncStart && vgaConfig.vsyncIrqEnable && vgaConfig.enableOutput,
		hSyncStart && vgaConfig.hsyncIrqEnable && vgaConfig.enableOutput};

endmodule

// ==== logic/scanTimer.sv ====
`timescale 1ns/100ps

module scanTimer #(
	parameter logic [vgaPkg::H_COUNT_BITS-1:0] H_VISIBLE_END = 799,
	parameter logic [vgaPkg::H_COUNT_BITS-1:0] H_FRONT_END = 839,
	parameter logic [vgaPkg::H_COUNT_BITS-1:0] H_SYNC_END = 967,
	parameter logic [vgaPkg::H_COUNT_BITS-1:0] H_WHOLE_END = 1055,
	parameter logic [vgaPkg::V_COUNT_BITS-1:0] V_VISIBLE_END = 599,
	parameter logic [vgaPkg::V_COUNT_BITS-1:0] V_FRONT_END = 600,
	parameter logic [vgaPkg::V_COUNT_BITS-1:0] V_SYNC_END = 604,
	parameter logic [vgaPkg::V_COUNT_BITS-1:0] V_WHOLE_END = 627
)(
	input logic vga_clk,
	input logic rst,
	input vgaPkg::vgaConfig_t vgaConfig,
	output vgaPkg::scanEvents_t events
);

	logic [vgaPkg::H_COUNT_BITS-1:0] hCount;
	logic [vgaPkg::V_COUNT_BITS-1:0] vCount;

	// Idle scan rests on the last cycle of the frame so line 0 starts right after
	always_ff @(posedge vga_clk) begin
		if (rst || !vgaConfig.enableOutput) begin
			hCount <= H_WHOLE_END;
			vCount <= V_WHOLE_END;
		end else if (events.lineEnd) begin
			hCount <= '0;
			if (events.vWholeEnd)
				vCount <= '0;
			else
				vCount <= vCount + 1'b1;
		end else begin
			hCount <= hCount + 1'b1;
		end
	end

	always_comb begin
		events.hVisibleEnd = hCount == H_VISIBLE_END;
		events.hFrontEnd = hCount == H_FRONT_END;
		events.hSyncEnd = hCount == H_SYNC_END;
		events.hWholeEnd = hCount == H_WHOLE_END;
		events.vVisibleEnd = vCount == V_VISIBLE_END;
		events.vFrontEnd = vCount == V_FRONT_END;
		events.vSyncEnd = vCount == V_SYNC_END;
		events.vWholeEnd = vCount == V_WHOLE_END;
		events.lineEnd = hCount == H_WHOLE_END;
	end

endmodule

// ==== common/vgaPkg.sv ====
package vgaPkg;

	// Frame-buffer word address with the byte offset in its two low bits
	localparam int ADDRESS_BITS = 13;

	localparam int H_COUNT_BITS = 11;
	localparam int V_COUNT_BITS = 10;

	localparam int PIXEL_SIZE_BITS = 4;

	// Five 6-bit pixels packed into each 32-bit word
	localparam int SUB_PIXELS = 5;
	localparam int PIXEL_BITS = 6;

	// Raw mode address fields
	localparam int ROW_FIELD_BITS = 7;
	localparam int COLUMN_FIELD_BITS = 4;

	typedef enum logic [1:0] {
		DRAW_RAW = 2'b00,
		DRAW_TIGHT = 2'b01
	} drawMode_e;

	typedef enum logic [1:0] {
		VISIBLE,
		FRONT_PORCH,
		SYNC,
		BACK_PORCH
	} scanPhase_e;

	typedef struct packed {
		logic [PIXEL_SIZE_BITS-1:0] horizontalPixelSize;
		logic [PIXEL_SIZE_BITS-1:0] verticalPixelSize;
		drawMode_e drawMode;
		logic enableOutput;
		logic hsyncIrqEnable;
		logic vsyncIrqEnable;
	} vgaConfig_t;

	// Vertical counter matches only count together with lineEnd
	typedef struct packed {
		logic hVisibleEnd;
		logic hFrontEnd;
		logic hSyncEnd;
		logic hWholeEnd;
		logic vVisibleEnd;
		logic vFrontEnd;
		logic vSyncEnd;
		logic vWholeEnd;
		logic lineEnd;
	} scanEvents_t;

	typedef struct packed {
		logic [1:0] red;
		logic [1:0] green;
		logic [1:0] blue;
	} colour_t;

endpackage
